// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := commit_trace_tb
FILELIST  := commit_trace.f
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "FAIL: see errors above" $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== commit_trace.f ====
source/trace_types_pkg.sv
source/pc_queue_pkg.sv
source/commit_classifier.sv
source/pc_fifo.sv
source/pc_rr_arbiter.sv
source/commit_trace_top.sv
verif/commit_trace_assertions.sv
verif/commit_trace_tb.sv

// ==== source/commit_classifier.sv ====
// ------------------------------------------------
// Commit classifier
// Sorts each port's commit into retire, exception
// or interrupt and registers the trace record
// ------------------------------------------------

module commit_classifier (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0]                      commit_ack_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0]                      ex_valid_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] pc_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] cause_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] tval_i,
  input  trace_types_pkg::priv_lvl_e                                  priv_lvl_i,
  output trace_types_pkg::trace_kind_e [pc_queue_pkg::NrCommitPorts-1:0] trace_kind_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0]                      trace_valid_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] trace_iaddr_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::InsnWidth-1:0] trace_insn_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] trace_cause_o,
  output trace_types_pkg::priv_lvl_e [pc_queue_pkg::NrCommitPorts-1:0] trace_priv_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0]                      push_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] push_pc_o
);

  import trace_types_pkg::*;
  import pc_queue_pkg::*;

  trace_kind_e [NrCommitPorts-1:0] kind_d;

  // ------------------------------------------------
  // Classification
  // ------------------------------------------------
  // Cause MSB set means the trap came from an interrupt
  always_comb begin
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (!commit_ack_i[p]) begin
        kind_d[p] = TraceNone;
      end else if (!ex_valid_i[p]) begin
        kind_d[p] = TraceRetire;
      end else if (cause_i[p][Xlen-1]) begin
        kind_d[p] = TraceInterrupt;
      end else begin
        kind_d[p] = TraceException;
      end
    end
  end

  // Only clean retirements go into the PC queues
  assign push_o    = commit_ack_i & ~ex_valid_i;
  assign push_pc_o = pc_i;

  // ------------------------------------------------
  // Trace record registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int p = 0; p < NrCommitPorts; p++) begin
        trace_kind_o[p]  <= TraceNone;
        trace_valid_o[p] <= 1'b0;
      end
    end else begin
      for (int p = 0; p < NrCommitPorts; p++) begin
        trace_kind_o[p]  <= kind_d[p];
        trace_valid_o[p] <= (kind_d[p] == TraceRetire);
      end
    end
  end

  // Payload follows the port whenever it commits
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (commit_ack_i[p]) begin
        trace_iaddr_o[p] <= pc_i[p];
        trace_insn_o[p]  <= tval_i[p][InsnWidth-1:0];
        trace_cause_o[p] <= cause_i[p];
        trace_priv_o[p]  <= priv_lvl_i;
      end
    end
  end

endmodule

// ==== source/commit_trace_top.sv ====
// ------------------------------------------------
// Commit trace top level
// Trace records per commit port plus a merged
// stream of retired PCs
// ------------------------------------------------

module commit_trace_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  // Commit ports
  input  logic [pc_queue_pkg::NrCommitPorts-1:0]                      commit_ack_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0]                      ex_valid_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] pc_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] cause_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] tval_i,
  input  trace_types_pkg::priv_lvl_e                                  priv_lvl_i,
  // Trace records
  output trace_types_pkg::trace_kind_e [pc_queue_pkg::NrCommitPorts-1:0] trace_kind_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0]                      trace_valid_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] trace_iaddr_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::InsnWidth-1:0] trace_insn_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] trace_cause_o,
  output trace_types_pkg::priv_lvl_e [pc_queue_pkg::NrCommitPorts-1:0] trace_priv_o,
  // PC stream
  output logic                                                        pc_valid_o,
  output logic [trace_types_pkg::Xlen-1:0]                            pc_o,
  output logic [pc_queue_pkg::PortIdxWidth-1:0]                       pc_port_o,
  output logic [pc_queue_pkg::NrCommitPorts-1:0]                      pc_overflow_o
);

  import trace_types_pkg::*;
  import pc_queue_pkg::*;

  // Classifier to queues
  logic [NrCommitPorts-1:0]           push;
  logic [NrCommitPorts-1:0][Xlen-1:0] push_pc;

  // Queues to arbiter and back
  logic [NrCommitPorts-1:0]           fifo_empty;
  logic [NrCommitPorts-1:0][Xlen-1:0] fifo_head;
  logic [NrCommitPorts-1:0]           fifo_pop;

  // ------------------------------------------------
  // Classifier
  // ------------------------------------------------
  commit_classifier i_commit_classifier (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .commit_ack_i  ( commit_ack_i  ),
    .ex_valid_i    ( ex_valid_i    ),
    .pc_i          ( pc_i          ),
    .cause_i       ( cause_i       ),
    .tval_i        ( tval_i        ),
    .priv_lvl_i    ( priv_lvl_i    ),
    .trace_kind_o  ( trace_kind_o  ),
    .trace_valid_o ( trace_valid_o ),
    .trace_iaddr_o ( trace_iaddr_o ),
    .trace_insn_o  ( trace_insn_o  ),
    .trace_cause_o ( trace_cause_o ),
    .trace_priv_o  ( trace_priv_o  ),
    .push_o        ( push          ),
    .push_pc_o     ( push_pc       )
  );

  // ------------------------------------------------
  // One PC queue per commit port
  // ------------------------------------------------
  for (genvar k = 0; k < NrCommitPorts; k++) begin : gen_pc_queue
    pc_fifo #(
      .Depth ( PcQueueDepth )
    ) i_pc_fifo (
      .clk_i      ( clk_i            ),
      .rst_ni     ( rst_ni           ),
      .push_i     ( push[k]          ),
      .data_i     ( push_pc[k]       ),
      .pop_i      ( fifo_pop[k]      ),
      .data_o     ( fifo_head[k]     ),
      .empty_o    ( fifo_empty[k]    ),
      .overflow_o ( pc_overflow_o[k] )
    );
  end

  // ------------------------------------------------
  // Merge into one PC stream
  // ------------------------------------------------
  pc_rr_arbiter i_pc_rr_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( fifo_empty ),
    .data_i     ( fifo_head  ),
    .pop_o      ( fifo_pop   ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       ),
    .pc_port_o  ( pc_port_o  )
  );

endmodule

// ==== source/pc_fifo.sv ====
// ------------------------------------------------
// PC FIFO
// Circular PC queue for one commit port, drops
// pushes when full and flags the loss until reset
// ------------------------------------------------

module pc_fifo #(
  // Power of two, at least 2
  parameter int unsigned Depth = pc_queue_pkg::PcQueueDepth
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             push_i,
  input  logic [trace_types_pkg::Xlen-1:0] data_i,
  input  logic                             pop_i,
  output logic [trace_types_pkg::Xlen-1:0] data_o,
  output logic                             empty_o,
  output logic                             overflow_o
);

  import trace_types_pkg::*;

  localparam int unsigned AddrWidth = $clog2(Depth);
  localparam int unsigned CntWidth  = $clog2(Depth + 1);

  logic [Xlen-1:0]      mem_q [Depth];
  logic [AddrWidth-1:0] wr_ptr_q;
  logic [AddrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 full;
  logic                 do_push;
  logic                 do_pop;

  assign full    = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);

  // A full queue refuses the write even if it pops this cycle
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      // Pointers wrap on their own since Depth is a power of two
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky, a lost PC stays reported
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== source/pc_queue_pkg.sv ====
// ------------------------------------------------
// PC queue sizing
// Commit ports, queue depth and port index width
// ------------------------------------------------

package pc_queue_pkg;

  // Instructions retired per cycle at most
  localparam int unsigned NrCommitPorts = 2;

  // Entries per port queue, power of two
  localparam int unsigned PcQueueDepth = 16;

  // Enough bits to name one port
  localparam int unsigned PortIdxWidth =
      (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

endpackage

// ==== source/pc_rr_arbiter.sv ====
// ------------------------------------------------
// PC round-robin arbiter
// Pops one non-empty queue per cycle and registers
// its head and port number into the PC stream
// ------------------------------------------------

module pc_rr_arbiter (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0]                      empty_i,
  input  logic [pc_queue_pkg::NrCommitPorts-1:0][trace_types_pkg::Xlen-1:0] data_i,
  output logic [pc_queue_pkg::NrCommitPorts-1:0]                      pop_o,
  output logic                                                        pc_valid_o,
  output logic [trace_types_pkg::Xlen-1:0]                            pc_o,
  output logic [pc_queue_pkg::PortIdxWidth-1:0]                       pc_port_o
);

  import trace_types_pkg::*;
  import pc_queue_pkg::*;

  logic [PortIdxWidth-1:0] rr_q;
  logic [PortIdxWidth-1:0] rr_d;
  logic [PortIdxWidth-1:0] gnt_idx;
  logic                    gnt_found;

  // ------------------------------------------------
  // Grant search
  // ------------------------------------------------
  // First non-empty port at or after the pointer, wrapping
  always_comb begin : p_grant
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      cand = (32'(rr_q) + i) % NrCommitPorts;
      if (!gnt_found && !empty_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand[PortIdxWidth-1:0];
      end
    end
  end

  // One-hot pop, never to an empty queue
  always_comb begin
    pop_o = '0;
    if (gnt_found) begin
      pop_o[gnt_idx] = 1'b1;
    end
  end

  // Pointer moves just past the granted port
  assign rr_d = (gnt_idx == PortIdxWidth'(NrCommitPorts - 1)) ? '0 : gnt_idx + 1'b1;

  // ------------------------------------------------
  // Pointer and output stream registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      pc_valid_o <= 1'b0;
    end else begin
      pc_valid_o <= gnt_found;
      if (gnt_found) begin
        rr_q <= rr_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_found) begin
      pc_o      <= data_i[gnt_idx];
      pc_port_o <= gnt_idx;
    end
  end

endmodule

// ==== source/trace_types_pkg.sv ====
// ------------------------------------------------
// Trace types
// Widths, privilege levels and record kinds that
// describe one committed instruction
// ------------------------------------------------

package trace_types_pkg;

  // Address and cause width
  localparam int unsigned Xlen = 64;

  // Instruction word, taken from the low bits of tval
  localparam int unsigned InsnWidth = 32;

  // RISC-V privilege encoding
  typedef enum logic [1:0] {
    PrivU = 2'b00,
    PrivS = 2'b01,
    PrivM = 2'b11
  } priv_lvl_e;

  // What a commit port did in one cycle
  typedef enum logic [1:0] {
    TraceNone      = 2'd0,
    TraceRetire    = 2'd1,
    TraceException = 2'd2,
    TraceInterrupt = 2'd3
  } trace_kind_e;

endpackage

// ==== verif/commit_trace_assertions.sv ====
// ------------------------------------------------
// Commit trace assertions
// Reset values, trace valid versus kind, overflow
// stickiness and minimum PC stream latency
// ------------------------------------------------

module commit_trace_assertions (
  input logic                                                         clk_i,
  input logic                                                         rst_ni,
  input logic [pc_queue_pkg::NrCommitPorts-1:0]                       commit_ack_i,
  input logic [pc_queue_pkg::NrCommitPorts-1:0]                       ex_valid_i,
  input trace_types_pkg::trace_kind_e [pc_queue_pkg::NrCommitPorts-1:0] trace_kind_o,
  input logic [pc_queue_pkg::NrCommitPorts-1:0]                       trace_valid_o,
  input logic                                                         pc_valid_o,
  input logic [pc_queue_pkg::NrCommitPorts-1:0]                       pc_overflow_o
);

  import trace_types_pkg::*;
  import pc_queue_pkg::*;

  logic seen_push_q;

  // Set by the first retirement that enters a PC queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_push_q <= 1'b0;
    end else if (|(commit_ack_i & ~ex_valid_i)) begin
      seen_push_q <= 1'b1;
    end
  end

  a_reset_idle: assert property (@(posedge clk_i)
      !rst_ni |-> (!pc_valid_o && (trace_valid_o == '0) && (pc_overflow_o == '0)))
    else $error("Stream or flag outputs active during reset");

  // Write at edge N, pop at N+1, so nothing shows before N+2
  a_pc_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pc_valid_o |-> $past(seen_push_q))
    else $error("pc_valid_o rose less than two cycles after the first retirement");

  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_port_checks
    a_kind_reset: assert property (@(posedge clk_i)
        !rst_ni |-> (trace_kind_o[p] == TraceNone))
      else $error("trace_kind_o not TraceNone during reset");

    a_valid_kind: assert property (@(posedge clk_i)
        trace_valid_o[p] == (trace_kind_o[p] == TraceRetire))
      else $error("trace_valid_o disagrees with trace_kind_o");

    a_overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(pc_overflow_o[p]) |-> pc_overflow_o[p])
      else $error("pc_overflow_o cleared without reset");
  end

endmodule

bind commit_trace_top commit_trace_assertions i_commit_trace_assertions (
  .clk_i         ( clk_i         ),
  .rst_ni        ( rst_ni        ),
  .commit_ack_i  ( commit_ack_i  ),
  .ex_valid_i    ( ex_valid_i    ),
  .trace_kind_o  ( trace_kind_o  ),
  .trace_valid_o ( trace_valid_o ),
  .pc_valid_o    ( pc_valid_o    ),
  .pc_overflow_o ( pc_overflow_o )
);

// ==== verif/commit_trace_input.txt ====
# Columns (hex): priv ack0 ex0 cause0 pc0 ack1 ex1 cause1 pc1
# priv 0 = U, 1 = S, 3 = M; cause MSB set marks an interrupt
3 1 0 0 80000000 0 0 0 0
3 1 0 0 80000004 1 0 0 80000008
3 1 0 0 8000000c 1 0 0 80000010
3 1 0 0 80000014 1 0 0 80000018
3 1 1 2 8000001c 1 0 0 80000020
3 0 0 0 0 0 0 0 0
1 1 0 0 ffffffc000001000 1 1 d ffffffc000001004
1 1 0 0 ffffffc000001008 1 0 0 ffffffc00000100c
1 1 1 8000000000000005 ffffffc000001010 0 0 0 0
1 0 0 0 0 1 0 0 ffffffc000001014
0 1 0 0 10074 1 0 0 10078
0 1 0 0 1007c 1 0 0 10080
0 1 1 8 10084 1 1 8000000000000009 10088
0 0 0 0 0 0 0 0 0
3 1 1 8000000000000007 80000100 1 0 0 80000104
3 1 0 0 80000108 1 0 0 8000010c
3 1 0 0 80000110 1 0 0 80000114
3 0 0 0 0 1 0 0 80000118
3 1 0 0 8000011c 0 0 0 0
3 1 0 0 80000120 1 1 3 80000124
3 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0

// ==== verif/commit_trace_tb.sv ====
// ------------------------------------------------
// Commit trace testbench
// File driven commits, reference model of trace
// records and PC queues, burst overflow test
// ------------------------------------------------

module commit_trace_tb;

  import trace_types_pkg::*;
  import pc_queue_pkg::*;

  localparam int    Seed         = 32'h1e0d5422;
  localparam int    ClkPeriod    = 40;
  localparam int    ResetCycles  = 16;
  localparam int    DriveDelay   = 2;
  localparam int    BurstCycles  = 56;
  localparam int    DrainTimeout = 100;
  localparam int    MaxCycles    = 1000;
  localparam string InputFile    = "verif/commit_trace_input.txt";

  logic                                    clk;
  logic                                    rst_n;
  logic [NrCommitPorts-1:0]                commit_ack;
  logic [NrCommitPorts-1:0]                ex_valid;
  logic [NrCommitPorts-1:0][Xlen-1:0]      pc;
  logic [NrCommitPorts-1:0][Xlen-1:0]      cause;
  logic [NrCommitPorts-1:0][Xlen-1:0]      tval;
  priv_lvl_e                               priv_lvl;
  trace_kind_e [NrCommitPorts-1:0]         trace_kind;
  logic [NrCommitPorts-1:0]                trace_valid;
  logic [NrCommitPorts-1:0][Xlen-1:0]      trace_iaddr;
  logic [NrCommitPorts-1:0][InsnWidth-1:0] trace_insn;
  logic [NrCommitPorts-1:0][Xlen-1:0]      trace_cause;
  priv_lvl_e [NrCommitPorts-1:0]           trace_priv;
  logic                                    pc_valid;
  logic [Xlen-1:0]                         pc_out;
  logic [PortIdxWidth-1:0]                 pc_port;
  logic [NrCommitPorts-1:0]                pc_overflow;

  // Reference model state
  logic [Xlen-1:0]          model_q [NrCommitPorts][$];
  logic [NrCommitPorts-1:0] model_ovf;
  logic [PortIdxWidth-1:0]  model_rr;
  trace_kind_e              exp_kind [NrCommitPorts];
  logic [Xlen-1:0]          exp_iaddr [NrCommitPorts];
  logic [InsnWidth-1:0]     exp_insn [NrCommitPorts];
  logic [Xlen-1:0]          exp_cause [NrCommitPorts];
  priv_lvl_e                exp_priv [NrCommitPorts];
  logic                     exp_pc_valid;
  logic [Xlen-1:0]          exp_pc;
  logic [PortIdxWidth-1:0]  exp_port;
  logic                     exp_both;
  logic                     last_valid;
  logic [PortIdxWidth-1:0]  last_port;
  int                       cur_line;
  int                       seed;
  int                       mismatch_count;
  int                       failure_count;

  commit_trace_top uut (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .commit_ack_i  ( commit_ack  ),
    .ex_valid_i    ( ex_valid    ),
    .pc_i          ( pc          ),
    .cause_i       ( cause       ),
    .tval_i        ( tval        ),
    .priv_lvl_i    ( priv_lvl    ),
    .trace_kind_o  ( trace_kind  ),
    .trace_valid_o ( trace_valid ),
    .trace_iaddr_o ( trace_iaddr ),
    .trace_insn_o  ( trace_insn  ),
    .trace_cause_o ( trace_cause ),
    .trace_priv_o  ( trace_priv  ),
    .pc_valid_o    ( pc_valid    ),
    .pc_o          ( pc_out      ),
    .pc_port_o     ( pc_port     ),
    .pc_overflow_o ( pc_overflow )
  );

  initial begin : p_clock
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_kind(input string name, input trace_kind_e got, input trace_kind_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      mismatch_count++;
    end
  endtask

  task automatic check_xlen(input string name, input logic [Xlen-1:0] got,
                            input logic [Xlen-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_insn(input string name, input logic [InsnWidth-1:0] got,
                            input logic [InsnWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_priv(input string name, input priv_lvl_e got, input priv_lvl_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_port(input string name, input logic [PortIdxWidth-1:0] got,
                            input logic [PortIdxWidth-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Predicts what the coming edge produces from the driven inputs
  task automatic model_step();
    int fill [NrCommitPorts];
    int cand;
    exp_pc_valid = 1'b0;
    exp_both     = 1'b1;
    for (int p = 0; p < NrCommitPorts; p++) begin
      fill[p] = model_q[p].size();
      if (fill[p] == 0) begin
        exp_both = 1'b0;
      end
      if (!commit_ack[p]) begin
        exp_kind[p] = TraceNone;
      end else if (!ex_valid[p]) begin
        exp_kind[p] = TraceRetire;
      end else if (cause[p][Xlen-1]) begin
        exp_kind[p] = TraceInterrupt;
      end else begin
        exp_kind[p] = TraceException;
      end
      if (commit_ack[p]) begin
        exp_iaddr[p] = pc[p];
        exp_insn[p]  = pc[p][InsnWidth-1:0] + InsnWidth'(cur_line);
        exp_cause[p] = cause[p];
        exp_priv[p]  = priv_lvl;
      end
    end
    // First non-empty queue from the pointer on
    for (int i = 0; i < NrCommitPorts; i++) begin
      cand = (int'(model_rr) + i) % NrCommitPorts;
      if (!exp_pc_valid && fill[cand] != 0) begin
        exp_pc_valid = 1'b1;
        exp_port     = PortIdxWidth'(cand);
        exp_pc       = model_q[cand].pop_front();
        model_rr     = PortIdxWidth'((cand + 1) % NrCommitPorts);
      end
    end
    // Full is judged on the fill before the edge
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (commit_ack[p] && !ex_valid[p]) begin
        if (fill[p] < PcQueueDepth) begin
          model_q[p].push_back(pc[p]);
        end else begin
          model_ovf[p] = 1'b1;
        end
      end
    end
  endtask

  function automatic bit queues_busy();
    for (int p = 0; p < NrCommitPorts; p++) begin
      if (model_q[p].size() != 0) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_outputs();
    for (int p = 0; p < NrCommitPorts; p++) begin
      check_kind($sformatf("trace_kind_o[%0d]", p), trace_kind[p], exp_kind[p]);
      check_flag($sformatf("trace_valid_o[%0d]", p), trace_valid[p], exp_kind[p] == TraceRetire);
      check_flag($sformatf("pc_overflow_o[%0d]", p), pc_overflow[p], model_ovf[p]);
      if (exp_kind[p] != TraceNone) begin
        check_xlen($sformatf("trace_iaddr_o[%0d]", p), trace_iaddr[p], exp_iaddr[p]);
        check_insn($sformatf("trace_insn_o[%0d]", p), trace_insn[p], exp_insn[p]);
        check_xlen($sformatf("trace_cause_o[%0d]", p), trace_cause[p], exp_cause[p]);
        check_priv($sformatf("trace_priv_o[%0d]", p), trace_priv[p], exp_priv[p]);
      end
    end
    check_flag("pc_valid_o", pc_valid, exp_pc_valid);
    if (exp_pc_valid) begin
      check_xlen("pc_o", pc_out, exp_pc);
      check_port("pc_port_o", pc_port, exp_port);
    end
    // Two busy queues must take turns
    if (pc_valid && last_valid && exp_both && pc_port == last_port) begin
      $display("Round-robin broken at %0t: port %0d served twice with both queues busy",
               $time, pc_port);
      failure_count++;
    end
    last_valid = pc_valid;
    last_port  = pc_port;
  endtask

  task automatic set_port(input int p, input logic ack, input logic ex,
                          input logic [Xlen-1:0] c, input logic [Xlen-1:0] addr, input int idx);
    commit_ack[p] = ack;
    ex_valid[p]   = ex;
    cause[p]      = c;
    pc[p]         = addr;
    tval[p]       = Xlen'(addr[InsnWidth-1:0] + InsnWidth'(idx));
  endtask

  task automatic next_cycle();
    model_step();
    @(posedge clk);
    #DriveDelay;
    check_outputs();
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : p_main
    int              fd;
    int              stim_lines;
    int              drain;
    string           text;
    logic [1:0]      priv_v;
    logic            a0, e0, a1, e1;
    logic [Xlen-1:0] c0, p0, c1, p1;
    logic [Xlen-1:0] addr;
    seed           = Seed;
    mismatch_count = 0;
    failure_count  = 0;
    rst_n          = 1'b0;
    commit_ack     = '0;
    ex_valid       = '0;
    pc             = '0;
    cause          = '0;
    tval           = '0;
    priv_lvl       = PrivM;
    model_ovf      = '0;
    model_rr       = '0;
    exp_pc_valid   = 1'b0;
    last_valid     = 1'b0;
    last_port      = '0;
    cur_line       = 0;
    stim_lines     = 0;
    for (int p = 0; p < NrCommitPorts; p++) begin
      exp_kind[p] = TraceNone;
    end
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;

    fd = $fopen(InputFile, "r");
    if (fd == 0) begin
      $display("Could not open stimulus file %s", InputFile);
      failure_count++;
    end else begin
      while ($fgets(text, fd) != 0) begin
        cur_line++;
        if (text.getc(0) != "#" &&
            $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                    priv_v, a0, e0, c0, p0, a1, e1, c1, p1) == 9) begin
          stim_lines++;
          priv_lvl = priv_lvl_e'(priv_v);
          set_port(0, a0, e0, c0, p0, cur_line);
          set_port(1, a1, e1, c1, p1, cur_line);
          next_cycle();
        end
      end
      $fclose(fd);
    end
    if (stim_lines == 0) begin
      $display("No stimulus lines were read from %s", InputFile);
      failure_count++;
    end

    // Burst with port 0 every cycle and port 1 every other cycle
    for (int i = 0; i < BurstCycles; i++) begin
      cur_line = i;
      priv_lvl = PrivM;
      addr     = {$random(seed), $random(seed)} & ~64'h3;
      set_port(0, 1'b1, 1'b0, '0, addr, i);
      set_port(1, (i % 2) == 0, 1'b0, '0, addr + 64'h4, i);
      next_cycle();
    end
    // Only port 0 gets more pushes than its share of grants
    check_flag("pc_overflow_o[0]", pc_overflow[0], 1'b1);
    check_flag("pc_overflow_o[1]", pc_overflow[1], 1'b0);

    commit_ack = '0;
    ex_valid   = '0;
    drain      = 0;
    while ((queues_busy() || exp_pc_valid) && drain < DrainTimeout) begin
      next_cycle();
      drain++;
    end
    if (drain >= DrainTimeout) begin
      $display("PC queues did not drain within %0d cycles", DrainTimeout);
      failure_count++;
    end

    $display("Done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : p_watchdog
    int cycles;
    cycles = 0;
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Simulation did not finish within %0d cycles", MaxCycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
